// File: Bender.yml
package:
  name: bch_decoder

# BCH(15,5) decoder, M=4, T=3.
sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bch_pkg.sv
      - hdl/bch_syndrome.sv
      - hdl/bch_codeword_buffer.sv
      - hdl/bch_key_solver.sv
      - hdl/bch_chien_corrector.sv
      - hdl/bch_decoder.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/bch_decoder_assert.sv
      - dv/bch_decoder_tb.sv

// File: dv/bch_decoder_assert.sv
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_decoder_assert (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_first,
	input logic syn_valid,
	input logic loc_valid,
	input logic out_valid,
	input logic out_last,
	input logic dec_fail
);
	localparam int CNT_W = $clog2(`BCH_N + 1);

	logic [CNT_W-1:0] in_cnt;
	logic [CNT_W-1:0] in_cnt_next;
	logic in_last;
	logic seen_input;
	logic out_idle_q; // No codeword was streaming out in the previous cycle.
	int fails = 0;

	// Input bit count kept independently of the DUT.
	assign in_cnt_next = in_first ? CNT_W'(1) : in_cnt + 1'b1;
	assign in_last = in_valid && (in_cnt_next == CNT_W'(`BCH_N));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_cnt <= '0;
			seen_input <= 1'b0;
			out_idle_q <= 1'b1;
		end else begin
			if (in_valid)
				in_cnt <= in_last ? '0 : in_cnt_next;
			seen_input <= seen_input || in_valid;
			out_idle_q <= !out_valid || out_last;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_input |-> !out_valid && !out_last && !dec_fail)
		else begin
			fails++;
			$error("Output active before any input was applied");
		end

	a_solver_latency: assert property (@(posedge clk) disable iff (!rst_n)
		syn_valid |-> ##4 loc_valid)
		else begin
			fails++;
			$error("loc_valid did not follow syn_valid after 4 cycles");
		end

	a_first_out: assert property (@(posedge clk) disable iff (!rst_n)
		in_last |-> ##6 (out_valid && out_idle_q))
		else begin
			fails++;
			$error("First corrected bit not 6 cycles after the last input bit");
		end

	a_last_out: assert property (@(posedge clk) disable iff (!rst_n)
		in_last |-> ##20 out_last)
		else begin
			fails++;
			$error("out_last not 20 cycles after the last input bit");
		end

	// Fifteen valid cycles in a row, the last one flagged.
	a_burst: assert property (@(posedge clk) disable iff (!rst_n)
		loc_valid |-> ##1 (out_valid && !out_last)[*14] ##1 (out_valid && out_last))
		else begin
			fails++;
			$error("Output burst is not 15 cycles ending in out_last");
		end

endmodule

bind bch_decoder bch_decoder_assert i_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.in_first  (in_first),
	.syn_valid (syn_valid),
	.loc_valid (loc_valid),
	.out_valid (out_valid),
	.out_last  (out_last),
	.dec_fail  (dec_fail)
);

// File: dv/bch_decoder_tb.sv
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_decoder_tb;

	localparam int PAR_W = `BCH_N - `BCH_K;
	localparam logic [`BCH_N-1:0] GEN_POLY = 'h537; // x^10+x^8+x^5+x^4+x^2+x+1.
	localparam int NUM_WORDS = 110;
	localparam int TIMEOUT = 20 * NUM_WORDS + 100;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_first;
	logic in_bit;
	logic out_valid;
	logic out_bit;
	logic out_last;
	logic dec_fail;

	int seed = 32'h353c_75bd;
	logic [`BCH_N-1:0] exp_q [$];
	int nerr_q [$];
	logic [`BCH_N-1:0] rx_word = '0;
	int cycles = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;

	always #2 clk = ~clk;

	bch_decoder i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_first  (in_first),
		.in_bit    (in_bit),
		.out_valid (out_valid),
		.out_bit   (out_bit),
		.out_last  (out_last),
		.dec_fail  (dec_fail)
	);

	// Long division by the generator, highest degree first.
	function automatic logic [PAR_W-1:0] poly_rem(input logic [`BCH_N-1:0] v);
		logic [`BCH_N-1:0] r;
		r = v;
		for (int i = `BCH_N - 1; i >= PAR_W; i--) begin
			if (r[i])
				r ^= GEN_POLY << (i - PAR_W);
		end
		return r[PAR_W-1:0];
	endfunction

	function automatic logic [`BCH_N-1:0] encode(input logic [`BCH_K-1:0] msg);
		logic [`BCH_N-1:0] shifted;
		shifted = {msg, {PAR_W{1'b0}}}; // Message in the top bits, parity below.
		return shifted | poly_rem(shifted);
	endfunction

	function automatic logic [`BCH_N-1:0] error_mask(input int count);
		logic [`BCH_N-1:0] mask;
		int pos;
		mask = '0;
		while ($countones(mask) < count) begin
			pos = $unsigned($random(seed)) % `BCH_N;
			mask[pos] = 1'b1; // Repeated positions are simply drawn again.
		end
		return mask;
	endfunction

	task automatic send_codeword(input logic [`BCH_N-1:0] cw);
		for (int i = `BCH_N - 1; i >= 0; i--) begin
			@(negedge clk);
			in_valid = 1'b1;
			in_first = (i == `BCH_N - 1);
			in_bit = cw[i];
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
			in_first = 1'b0;
			in_bit = 1'b0;
		end
	endtask

	task automatic check_word(input logic [`BCH_N-1:0] rx, input logic fail_flag);
		logic [`BCH_N-1:0] exp;
		int nerr;
		logic ok;
		if (exp_q.size() == 0) begin
			$display("Codeword came out at %0t with none outstanding", $time);
			fail_cnt++;
		end else begin
			exp = exp_q.pop_front();
			nerr = nerr_q.pop_front();
			// Past T errors a flagged failure or any valid codeword is acceptable.
			if (nerr <= `BCH_T)
				ok = (rx == exp) && !fail_flag;
			else
				ok = fail_flag || (poly_rem(rx) == '0);
			if (ok) begin
				pass_cnt++;
			end else begin
				$display("** Error at %0t: got %h dec_fail %b, sent %h with %0d errors",
					$time, rx, fail_flag, exp, nerr);
				fail_cnt++;
			end
		end
	endtask

	task automatic run_test(input string name, input int words, input int min_err,
			input int max_err, input int gap);
		logic [`BCH_K-1:0] msg;
		logic [`BCH_N-1:0] cw;
		int nerr;
		int fails_before;
		fails_before = fail_cnt;
		for (int w = 0; w < words; w++) begin
			msg = $random(seed);
			cw = encode(msg);
			nerr = min_err + $unsigned($random(seed)) % (max_err - min_err + 1);
			exp_q.push_back(cw);
			nerr_q.push_back(nerr);
			send_codeword(cw ^ error_mask(nerr));
			idle(gap);
		end
		idle(1);
		while (exp_q.size() != 0)
			@(posedge clk);
		$display("%s: %0d codewords, %0d failed", name, words, fail_cnt - fails_before);
	endtask

	always @(posedge clk) begin
		if (rst_n && out_valid) begin
			rx_word = {rx_word[`BCH_N-2:0], out_bit};
			if (out_last)
				check_word(rx_word, dec_fail);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_bit = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		idle(10); // The bound assertions watch the idle outputs here.
		$display("reset_state: done");
		run_test("error_free", 20, 0, 0, 2);
		run_test("correctable", 30, 1, 3, 2);
		run_test("back_to_back", 40, 0, 3, 0);
		run_test("beyond_capability", 20, 4, 5, 2);
		idle(5);
		$display("Summary: %0d passed, %0d failed, %0d assertion failures",
			pass_cnt, fail_cnt, i_dut.i_assert.fails);
		if (fail_cnt == 0 && i_dut.i_assert.fails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: hdl/bch_chien_corrector.sv
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_chien_corrector (
	input  logic clk,
	input  logic rst_n,
	input  logic loc_valid,
	input  bch_pkg::locator_t loc,
	output logic rd_en,
	input  logic rd_bit,
	output logic out_valid,
	output logic out_bit,
	output logic out_last,
	output logic dec_fail
);
	import bch_pkg::*;

	localparam int POS_W = $clog2(`BCH_N);
	localparam int ROOT_W = $clog2(`BCH_N + 1);

	gf_elem_t term_q [`BCH_T+1];
	gf_elem_t term_cur [`BCH_T+1];
	gf_elem_t eval;
	logic active;
	logic hit;
	logic last_pos;
	logic [POS_W-1:0] pos_q;
	logic [POS_W-1:0] pos_cur;
	logic [ROOT_W-1:0] roots_q;
	logic [ROOT_W-1:0] roots_cur;
	logic [DEG_W-1:0] degree_q;
	logic [DEG_W-1:0] degree_cur;

	// Position p is in error when sigma(alpha^(15-p)) is zero. Position 14
	// is evaluated straight from the locator in the cycle it arrives, the
	// later ones from the stepped terms.
	always_comb begin
		eval = GF_ZERO;
		for (int i = 0; i <= `BCH_T; i++) begin
			if (loc_valid)
				term_cur[i] = gf_mul(loc.sigma[i], gf_alpha_pow(i));
			else
				term_cur[i] = term_q[i];
			eval ^= term_cur[i];
		end
	end

	assign hit = eval == GF_ZERO;
	assign rd_en = loc_valid || active; // One buffer bit per evaluated position.
	assign pos_cur = loc_valid ? POS_W'(`BCH_N - 1) : pos_q;
	assign last_pos = pos_cur == '0;
	assign roots_cur = (loc_valid ? ROOT_W'(0) : roots_q) + ROOT_W'(hit);
	assign degree_cur = loc_valid ? loc.degree : degree_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			pos_q <= '0;
			roots_q <= '0;
			degree_q <= '0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
			dec_fail <= 1'b0;
		end else begin
			out_valid <= rd_en;
			out_last <= rd_en && last_pos;
			// A locator whose root count differs from its degree means more
			// errors than the code can correct.
			dec_fail <= rd_en && last_pos && (roots_cur != ROOT_W'(degree_cur));
			if (rd_en) begin
				active <= !last_pos;
				pos_q <= pos_cur - 1'b1;
				roots_q <= roots_cur;
				degree_q <= degree_cur;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			for (int i = 0; i <= `BCH_T; i++)
				term_q[i] <= gf_mul(term_cur[i], gf_alpha_pow(i)); // Step to next position.
			out_bit <= rd_bit ^ hit;
		end
	end

endmodule

// File: hdl/bch_codeword_buffer.sv
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_codeword_buffer (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic in_first,
	input  logic in_bit,
	input  logic rd_en,
	output logic rd_bit
);
	// One entry filling, one waiting on the solver, one streaming out.
	localparam int DEPTH = 3;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int IDX_W = $clog2(`BCH_N);

	logic [`BCH_N-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] wr_pos;
	logic [IDX_W-1:0] rd_idx;
	logic wr_last;
	logic rd_last;

	assign wr_pos = in_first ? '0 : wr_idx;
	assign wr_last = in_valid && (wr_pos == IDX_W'(`BCH_N - 1));
	assign rd_last = rd_idx == IDX_W'(`BCH_N - 1);

	// The first bit received ends up in the top bit of the entry.
	assign rd_bit = mem[rd_ptr][IDX_W'(`BCH_N - 1) - rd_idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			wr_idx <= '0;
			rd_ptr <= '0;
			rd_idx <= '0;
		end else begin
			if (in_valid) begin
				wr_idx <= wr_last ? '0 : wr_pos + 1'b1;
				if (wr_last)
					wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_idx <= rd_last ? '0 : rd_idx + 1'b1;
				if (rd_last)
					rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// Each entry is a shift register, so a restarted codeword simply overwrites it.
	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= {mem[wr_ptr][`BCH_N-2:0], in_bit};
	end

endmodule

// File: hdl/bch_decoder.sv
`timescale 1ns/1ps

module bch_decoder (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic in_first,
	input  logic in_bit,
	output logic out_valid,
	output logic out_bit,
	output logic out_last,
	output logic dec_fail
);
	import bch_pkg::*;

	logic syn_valid;
	syndromes_t syn;
	logic loc_valid;
	locator_t loc;
	logic rd_en;
	logic rd_bit;

	bch_syndrome i_syndrome (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_first  (in_first),
		.in_bit    (in_bit),
		.syn_valid (syn_valid),
		.syn       (syn)
	);

	// Raw bits wait here until the locator for their codeword is ready.
	bch_codeword_buffer i_buffer (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_first (in_first),
		.in_bit   (in_bit),
		.rd_en    (rd_en),
		.rd_bit   (rd_bit)
	);

	bch_key_solver i_solver (
		.clk       (clk),
		.rst_n     (rst_n),
		.syn_valid (syn_valid),
		.syn       (syn),
		.loc_valid (loc_valid),
		.loc       (loc)
	);

	bch_chien_corrector i_corrector (
		.clk       (clk),
		.rst_n     (rst_n),
		.loc_valid (loc_valid),
		.loc       (loc),
		.rd_en     (rd_en),
		.rd_bit    (rd_bit),
		.out_valid (out_valid),
		.out_bit   (out_bit),
		.out_last  (out_last),
		.dec_fail  (dec_fail)
	);

endmodule

// File: hdl/bch_key_solver.sv
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_key_solver (
	input  logic clk,
	input  logic rst_n,
	input  logic syn_valid,
	input  bch_pkg::syndromes_t syn,
	output logic loc_valid,
	output bch_pkg::locator_t loc
);
	import bch_pkg::*;

	localparam int STEP_W = $clog2(`BCH_T);
	localparam int LEN_W = $clog2(2 * `BCH_T);

	solver_state_t state;
	logic [STEP_W-1:0] step;
	logic last_step;
	syndromes_t syn_q;
	gf_elem_t s [2*`BCH_T];
	gf_elem_t [`BCH_T:0] sigma_q;
	gf_elem_t [`BCH_T:0] sigma_d;
	gf_elem_t [`BCH_T:0] beta_q; // Multiplied by x when it enters sigma.
	gf_elem_t [`BCH_T:0] beta_d;
	gf_elem_t gamma_q; // Previous nonzero discrepancy.
	gf_elem_t gamma_d;
	gf_elem_t delta;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] len_d;
	logic upd;

	assign last_step = step == STEP_W'(`BCH_T - 1);

	always_comb begin
		s[0] = GF_ZERO;
		s[1] = syn_q.s1;
		s[2] = syn_q.s2;
		s[3] = syn_q.s3;
		s[4] = syn_q.s4;
		s[5] = syn_q.s5;
	end

	// Only odd discrepancies are computed. The even ones of a binary code
	// are always zero, which is why T steps are enough.
	always_comb begin
		int idx;
		delta = GF_ZERO;
		for (int i = 0; i <= `BCH_T; i++) begin
			idx = 2 * int'(step) + 1 - i;
			if (idx >= 0)
				delta ^= gf_mul(sigma_q[i], s[idx]);
		end
	end

	always_comb begin
		upd = (delta != GF_ZERO) && (int'(len_q) <= int'(step));
		sigma_d[0] = gf_mul(gamma_q, sigma_q[0]);
		for (int i = 1; i <= `BCH_T; i++)
			sigma_d[i] = gf_mul(gamma_q, sigma_q[i]) ^ gf_mul(delta, beta_q[i-1]);
		beta_d[0] = GF_ZERO;
		beta_d[1] = upd ? sigma_q[0] : GF_ZERO;
		for (int i = 2; i <= `BCH_T; i++)
			beta_d[i] = upd ? sigma_q[i-1] : beta_q[i-2]; // x*sigma or x^2*beta.
		gamma_d = upd ? delta : gamma_q;
		len_d = upd ? LEN_W'(2 * int'(step) + 1 - int'(len_q)) : len_q;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SOLVER_IDLE;
			step <= '0;
			loc_valid <= 1'b0;
		end else begin
			loc_valid <= 1'b0;
			if (syn_valid) begin
				state <= SOLVER_ITERATE;
				step <= '0;
			end else if (state == SOLVER_ITERATE) begin
				step <= step + 1'b1;
				if (last_step) begin
					state <= SOLVER_IDLE;
					loc_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (syn_valid) begin
			syn_q <= syn;
			sigma_q <= {{`BCH_T{GF_ZERO}}, GF_ONE};
			beta_q <= {{`BCH_T{GF_ZERO}}, GF_ONE};
			gamma_q <= GF_ONE;
			len_q <= '0;
		end else if (state == SOLVER_ITERATE) begin
			sigma_q <= sigma_d;
			beta_q <= beta_d;
			gamma_q <= gamma_d;
			len_q <= len_d;
		end
		// A locator longer than T cannot be right. A constant sigma then finds
		// no roots against a degree of T, and the corrector flags the failure.
		if (state == SOLVER_ITERATE && last_step) begin
			if (len_d > LEN_W'(`BCH_T)) begin
				loc.sigma <= {{`BCH_T{GF_ZERO}}, GF_ONE};
				loc.degree <= DEG_W'(`BCH_T);
			end else begin
				loc.sigma <= sigma_d;
				loc.degree <= DEG_W'(len_d);
			end
		end
	end

endmodule

// File: hdl/bch_pkg.sv
`include "bch_settings.svh"

package bch_pkg;

	localparam int DEG_W = $clog2(`BCH_T + 1);

	typedef logic [`BCH_M-1:0] gf_elem_t;

	localparam gf_elem_t GF_ZERO = '0;
	localparam gf_elem_t GF_ONE = gf_elem_t'(1);
	localparam gf_elem_t GF_ALPHA = gf_elem_t'(2);

	// S1 sits in the low bits.
	typedef struct packed {
		gf_elem_t s6;
		gf_elem_t s5;
		gf_elem_t s4;
		gf_elem_t s3;
		gf_elem_t s2;
		gf_elem_t s1;
	} syndromes_t;

	typedef struct packed {
		gf_elem_t [`BCH_T:0] sigma; // Index i holds the coefficient of x^i.
		logic [DEG_W-1:0] degree;
	} locator_t;

	typedef enum logic {
		SOLVER_IDLE,
		SOLVER_ITERATE
	} solver_state_t;

	// Shift and add multiply, reducing by the field polynomial at every shift.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t p;
		gf_elem_t x;
		p = GF_ZERO;
		x = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				p ^= x;
			x = x[`BCH_M-1] ? ((x << 1) ^ gf_elem_t'(`BCH_POLY)) : (x << 1);
		end
		return p;
	endfunction

	function automatic gf_elem_t gf_square(input gf_elem_t a);
		return gf_mul(a, a);
	endfunction

	// Meant for constant exponents, the loop folds away in synthesis.
	function automatic gf_elem_t gf_alpha_pow(input int unsigned e);
		gf_elem_t p;
		p = GF_ONE;
		for (int k = 0; k < `BCH_N; k++) begin
			if (k < e % `BCH_N)
				p = gf_mul(p, GF_ALPHA);
		end
		return p;
	endfunction

endpackage

// File: hdl/bch_settings.svh
`ifndef BCH_SETTINGS_SVH
`define BCH_SETTINGS_SVH

// Width of one GF(2^M) element in bits.
`define BCH_M 4

// Number of bit errors the decoder corrects per codeword.
`define BCH_T 3

// Codeword length, 2^M - 1.
`define BCH_N 15

// Message length of the BCH(15,5) code.
`define BCH_K 5

// Primitive polynomial x^4 + x + 1.
`define BCH_POLY 5'b10011

`endif

// File: hdl/bch_syndrome.sv
`timescale 1ns/1ps
`include "bch_settings.svh"

module bch_syndrome (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic in_first,
	input  logic in_bit,
	output logic syn_valid,
	output bch_pkg::syndromes_t syn
);
	import bch_pkg::*;

	localparam int CNT_W = $clog2(`BCH_N + 1);

	gf_elem_t acc_q [`BCH_T];
	gf_elem_t acc_d [`BCH_T];
	gf_elem_t s1_sq;
	logic [CNT_W-1:0] bit_cnt;
	logic [CNT_W-1:0] cnt_d;
	logic last_bit;

	// Horner step for the odd syndromes. Accumulator k evaluates the
	// received polynomial at alpha^(2k+1), highest degree bit first.
	always_comb begin
		for (int k = 0; k < `BCH_T; k++) begin
			if (in_first)
				acc_d[k] = gf_elem_t'(in_bit);
			else
				acc_d[k] = gf_mul(acc_q[k], gf_alpha_pow(2 * k + 1)) ^ gf_elem_t'(in_bit);
		end
	end

	assign cnt_d = in_first ? CNT_W'(1) : bit_cnt + 1'b1; // Bits seen including this one.
	assign last_bit = in_valid && (cnt_d == CNT_W'(`BCH_N));

	// Binary codes give S2j = Sj^2, so the even syndromes need no accumulator.
	assign s1_sq = gf_square(acc_d[0]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			syn_valid <= 1'b0;
		end else begin
			syn_valid <= last_bit;
			if (in_valid)
				bit_cnt <= last_bit ? '0 : cnt_d;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			acc_q <= acc_d;
		if (last_bit) begin
			syn.s1 <= acc_d[0];
			syn.s2 <= s1_sq;
			syn.s3 <= acc_d[1];
			syn.s4 <= gf_square(s1_sq);
			syn.s5 <= acc_d[2];
			syn.s6 <= gf_square(acc_d[1]);
		end
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/bch_pkg.sv
hdl/bch_syndrome.sv
hdl/bch_codeword_buffer.sv
hdl/bch_key_solver.sv
hdl/bch_chien_corrector.sv
hdl/bch_decoder.sv
dv/bch_decoder_assert.sv
dv/bch_decoder_tb.sv
